//--- ddr_traffic_checker_testdata.txt
// Fields: kind op base count seed corrupt0 corrupt1 corrupt2 corrupt3 flag errors first_err
// Kind 1 runs at once, kind 2 holds calibration low for 200 cycles; op 0 wr, 1 rd chk, 2 wr-rd
1_2_0001000_0010_12345678_fffffff_fffffff_fffffff_fffffff_0_0000_0000000
1_2_0002000_0020_cafef00d_0002040_0002008_00020f8_0003000_1_0003_0002008
1_0_0004000_0040_0badcafe_fffffff_fffffff_fffffff_fffffff_0_0000_0000000
1_1_0004000_0040_0badcafe_fffffff_fffffff_fffffff_fffffff_0_0000_0000000
1_1_0004000_0040_00000001_fffffff_fffffff_fffffff_fffffff_1_0040_0004000
2_2_0008000_0008_00000000_fffffff_fffffff_fffffff_fffffff_0_0000_0000000
1_2_0009000_0000_5a5a5a5a_0009000_fffffff_fffffff_fffffff_0_0000_0000000
1_2_ffffff0_0004_13579bdf_0000000_fffffff_fffffff_fffffff_1_0001_0000000

//--- ddr_traffic_checker.f
+incdir+.
ddr_app_pkg.sv
ddr_test_pkg.sv
ddr_test_ctrl.sv
ddr_addr_gen.sv
ddr_pattern_gen.sv
ddr_read_checker.sv
ddr_traffic_checker.sv
tb_ddr_mem_model.sv
tb_ddr_traffic_checker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr_traffic_checker
FILELIST  ?= ddr_traffic_checker.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_ddr_traffic_checker.sv
`timescale 1ns/1ps

module tb_ddr_traffic_checker;

  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  localparam int MAX_TESTS   = 16;
  localparam int ACK_TIMEOUT = 20000;
  localparam int REL_TIMEOUT = 16;

  logic            c0_ddr4_clk = 1'b0;
  logic            rst_n;
  logic            req;
  logic            ack;
  test_op_e        opcode;
  app_addr_t       base_addr;
  word_cnt_t       word_count;
  logic [31:0]     seed;
  logic            calib;
  app_addr_t       app_addr;
  app_cmd_e        app_cmd;
  logic            app_en;
  logic            app_rdy;
  app_data_t       app_wdf_data;
  logic            app_wdf_wren;
  logic            app_wdf_end;
  logic            app_wdf_rdy;
  app_data_t       app_rd_data;
  logic            app_rd_data_valid;
  logic            cmp_err;
  err_cnt_t        err_cnt;
  app_addr_t       first_err;
  app_addr_t [3:0] corrupt;
  logic [243:0]    tests [MAX_TESTS];
  int              mismatch_cnt;
  int              fail_cnt;
  int              timeout_cnt;
  int              tests_run;
  int              mon_fail_cnt = 0;
  int              cmd_total = 0;
  logic            aborted;

  always #5 c0_ddr4_clk = ~c0_ddr4_clk;

  ddr_traffic_checker ddr_traffic_checker_i (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n),
    .req_i                 (req),
    .ack_o                 (ack),
    .opcode_i              (opcode),
    .base_addr_i           (base_addr),
    .word_count_i          (word_count),
    .seed_i                (seed),
    .init_calib_complete_i (calib),
    .app_addr_o            (app_addr),
    .app_cmd_o             (app_cmd),
    .app_en_o              (app_en),
    .app_rdy_i             (app_rdy),
    .app_wdf_data_o        (app_wdf_data),
    .app_wdf_wren_o        (app_wdf_wren),
    .app_wdf_end_o         (app_wdf_end),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .app_rd_data_i         (app_rd_data),
    .app_rd_data_valid_i   (app_rd_data_valid),
    .compare_error_o       (cmp_err),
    .error_count_o         (err_cnt),
    .first_err_addr_o      (first_err)
  );

  tb_ddr_mem_model u_mem_model (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .rst_n_i             (rst_n),
    .app_addr_i          (app_addr),
    .app_cmd_i           (app_cmd),
    .app_en_i            (app_en),
    .app_rdy_o           (app_rdy),
    .app_wdf_data_i      (app_wdf_data),
    .app_wdf_wren_i      (app_wdf_wren),
    .app_wdf_rdy_o       (app_wdf_rdy),
    .app_rd_data_o       (app_rd_data),
    .app_rd_data_valid_o (app_rd_data_valid),
    .corrupt_addr_i      (corrupt)
  );

  //******************************
  // Bus monitor
  //******************************
  always @(posedge c0_ddr4_clk) begin
    if (rst_n) begin
      if (app_en && app_rdy && ((app_cmd == CMD_READ) || (app_wdf_wren && app_wdf_rdy))) begin
        cmd_total <= cmd_total + 1;
      end
      if (app_en && !calib) begin
        mon_fail_cnt <= mon_fail_cnt + 1;
        $display("Command issued while calibration is incomplete at %0t", $time);
      end
      if (app_wdf_wren && !app_wdf_end) begin
        mon_fail_cnt <= mon_fail_cnt + 1;
        $display("Write data without app_wdf_end_o at %0t", $time);
      end
    end
  end

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic check_err_cnt(input string name, input err_cnt_t exp, input err_cnt_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input app_addr_t exp, input app_addr_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Polls on the falling edge until ack_o reaches the level
  task automatic wait_ack(input string name, input logic level, input int limit,
                          output int cycles);
    cycles = 0;
    while ((ack !== level) && !aborted) begin
      @(negedge c0_ddr4_clk);
      cycles++;
      if ((ack !== level) && (cycles >= limit)) begin
        timeout_cnt++;
        aborted = 1'b1;
        $display("%s timed out after %0d cycles waiting for ack_o to be %0b",
                 name, cycles, level);
      end
    end
  endtask

  task automatic run_test(input int idx, input logic [243:0] rec);
    string     name;
    test_op_e  op;
    word_cnt_t cnt;
    logic      exp_flag;
    err_cnt_t  exp_err;
    app_addr_t exp_first;
    int        exp_cmds;
    int        cmd_start;
    int        cycles;
    int        i;
    logic      flag_hold;
    err_cnt_t  err_hold;
    app_addr_t addr_hold;
    name      = $sformatf("test%0d", idx);
    op        = test_op_e'(rec[237:236]);
    cnt       = rec[207:192];
    exp_flag  = rec[44];
    exp_err   = rec[43:28];
    exp_first = rec[27:0];
    exp_cmds  = (op == OP_WRITE_READ) ? 2 * int'(cnt) : int'(cnt);

    @(negedge c0_ddr4_clk);
    opcode     = op;
    base_addr  = rec[235:208];
    word_count = cnt;
    seed       = rec[191:160];
    corrupt    = rec[159:48];
    cmd_start  = cmd_total;
    if (rec[243:240] == 4'h2) begin
      calib = 1'b0;
    end
    req = 1'b1;

    // Calibration held back, the engine must stay quiet
    if (rec[243:240] == 4'h2) begin
      for (i = 0; i < 200; i++) begin
        @(negedge c0_ddr4_clk);
        if (ack) begin
          fail_cnt++;
          $display("%s ack_o rose while calibration is incomplete", name);
        end
      end
      calib = 1'b1;
    end

    wait_ack(name, 1'b1, ACK_TIMEOUT, cycles);
    if (aborted) begin
      return;
    end
    check_flag({name, " compare_error"}, exp_flag, cmp_err);
    check_err_cnt({name, " error_count"}, exp_err, err_cnt);
    check_addr({name, " first_err_addr"}, exp_first, first_err);
    check_count({name, " commands"}, exp_cmds, cmd_total - cmd_start);

    // Results must not move while ack_o is high
    flag_hold = cmp_err;
    err_hold  = err_cnt;
    addr_hold = first_err;
    for (i = 0; i < 4; i++) begin
      @(negedge c0_ddr4_clk);
      if (!ack) begin
        fail_cnt++;
        $display("%s ack_o dropped while req_i was still high", name);
      end
      check_flag({name, " held compare_error"}, flag_hold, cmp_err);
      check_err_cnt({name, " held error_count"}, err_hold, err_cnt);
      check_addr({name, " held first_err_addr"}, addr_hold, first_err);
    end

    req = 1'b0;
    wait_ack(name, 1'b0, REL_TIMEOUT, cycles);
    if (aborted) begin
      return;
    end
    check_count({name, " ack release cycles"}, 1, cycles);
  endtask

  initial begin
    int   idx;
    logic more;
    rst_n        = 1'b0;
    req          = 1'b0;
    opcode       = OP_WRITE;
    base_addr    = '0;
    word_count   = '0;
    seed         = '0;
    calib        = 1'b0;
    corrupt      = '1;
    aborted      = 1'b0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    timeout_cnt  = 0;
    tests_run    = 0;
    $readmemh("ddr_traffic_checker_testdata.txt", tests);

    repeat (10) @(negedge c0_ddr4_clk);
    rst_n = 1'b1;
    calib = 1'b1;

    idx  = 0;
    more = 1'b1;
    while (more && !aborted && (idx < MAX_TESTS)) begin
      case (tests[idx][243:240])
        4'h1, 4'h2: begin
          run_test(idx, tests[idx]);
          tests_run++;
        end
        default: more = 1'b0;
      endcase
      idx++;
    end
    if (tests_run == 0) begin
      fail_cnt++;
      $display("No tests were read from the data file");
    end

    $display("Tests run %0d, mismatches %0d, failures %0d, timeouts %0d",
             tests_run, mismatch_cnt, fail_cnt + mon_fail_cnt, timeout_cnt);
    if ((mismatch_cnt + fail_cnt + mon_fail_cnt + timeout_cnt) == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tb_ddr_mem_model.sv
`timescale 1ns/1ps

module tb_ddr_mem_model (
  input  logic                        c0_ddr4_clk,
  input  logic                        rst_n_i,
  input  ddr_app_pkg::app_addr_t      app_addr_i,
  input  ddr_app_pkg::app_cmd_e       app_cmd_i,
  input  logic                        app_en_i,
  output logic                        app_rdy_o,
  input  ddr_app_pkg::app_data_t      app_wdf_data_i,
  input  logic                        app_wdf_wren_i,
  output logic                        app_wdf_rdy_o,
  output ddr_app_pkg::app_data_t      app_rd_data_o,
  output logic                        app_rd_data_valid_o,
  input  ddr_app_pkg::app_addr_t [3:0] corrupt_addr_i
);

  import ddr_app_pkg::*;

  app_data_t   mem [app_addr_t];
  app_data_t   rd_data_q [$];
  int          rd_due_q [$];
  int          cycle;
  logic [31:0] lfsr;
  logic        rdy_nxt;
  logic        wdf_rdy_nxt;
  logic        valid_nxt;
  app_data_t   data_nxt;

  // Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit taken
  function automatic int take_bits(input int n);
    int val;
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = (val << 1) | int'(lfsr[0]);
    end
    return val;
  endfunction

  // Unwritten words read back a pattern built from the full address
  function automatic app_data_t read_word(input app_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {4'hf, ~a, 4'h0, a};
  endfunction

  function automatic logic is_corrupt(input app_addr_t a);
    logic hit;
    int   i;
    hit = 1'b0;
    for (i = 0; i < 4; i++) begin
      if (corrupt_addr_i[i] == a) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //******************************
  // Accept commands, schedule reads
  //******************************
  always @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      lfsr        = 32'h7b60c06e;
      cycle       = 0;
      rdy_nxt     = 1'b0;
      wdf_rdy_nxt = 1'b0;
      valid_nxt   = 1'b0;
      data_nxt    = '0;
      rd_data_q.delete();
      rd_due_q.delete();
    end else begin
      cycle++;
      // A write moves only when command and data go together
      if (app_en_i && app_rdy_o && (app_cmd_i == CMD_WRITE) && app_wdf_wren_i && app_wdf_rdy_o) begin
        mem[app_addr_i] = is_corrupt(app_addr_i) ? (app_wdf_data_i ^ app_data_t'(1))
                                                 : app_wdf_data_i;
      end
      if (app_en_i && app_rdy_o && (app_cmd_i == CMD_READ)) begin
        rd_data_q.push_back(read_word(app_addr_i));
        rd_due_q.push_back(cycle + take_bits(3) + 1);
      end
      // In order, the head may hold back later words
      valid_nxt = 1'b0;
      if ((rd_due_q.size() > 0) && (rd_due_q[0] <= cycle)) begin
        valid_nxt = 1'b1;
        data_nxt  = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end
      rdy_nxt     = (take_bits(2) != 0);
      wdf_rdy_nxt = (take_bits(2) != 0);
    end
  end

  // Outputs change on the falling edge
  always @(negedge c0_ddr4_clk) begin
    app_rdy_o           <= rdy_nxt;
    app_wdf_rdy_o       <= wdf_rdy_nxt;
    app_rd_data_valid_o <= valid_nxt;
    app_rd_data_o       <= data_nxt;
  end

endmodule

//--- ddr_traffic_checker.sv
`timescale 1ns/1ps

module ddr_traffic_checker (
  input  logic                    c0_ddr4_clk,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  output logic                    ack_o,
  input  ddr_test_pkg::test_op_e  opcode_i,
  input  ddr_app_pkg::app_addr_t  base_addr_i,
  input  ddr_test_pkg::word_cnt_t word_count_i,
  input  logic [31:0]             seed_i,
  input  logic                    init_calib_complete_i,
  output ddr_app_pkg::app_addr_t  app_addr_o,
  output ddr_app_pkg::app_cmd_e   app_cmd_o,
  output logic                    app_en_o,
  input  logic                    app_rdy_i,
  output ddr_app_pkg::app_data_t  app_wdf_data_o,
  output logic                    app_wdf_wren_o,
  output logic                    app_wdf_end_o,
  input  logic                    app_wdf_rdy_i,
  input  ddr_app_pkg::app_data_t  app_rd_data_i,
  input  logic                    app_rd_data_valid_i,
  output logic                    compare_error_o,
  output ddr_test_pkg::err_cnt_t  error_count_o,
  output ddr_app_pkg::app_addr_t  first_err_addr_o
);

  import ddr_app_pkg::*;

  logic      addr_load;
  logic      addr_step;
  logic      wr_pat_load;
  logic      wr_pat_step;
  logic      rd_pat_load;
  logic      rd_pat_step;
  logic      chk_clear;
  app_data_t exp_data;

  //******************************
  // Sequencer
  //******************************
  ddr_test_ctrl u_ctrl (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n_i),
    .req_i                 (req_i),
    .ack_o                 (ack_o),
    .opcode_i              (opcode_i),
    .word_count_i          (word_count_i),
    .init_calib_complete_i (init_calib_complete_i),
    .app_rdy_i             (app_rdy_i),
    .app_wdf_rdy_i         (app_wdf_rdy_i),
    .app_rd_data_valid_i   (app_rd_data_valid_i),
    .app_en_o              (app_en_o),
    .app_cmd_o             (app_cmd_o),
    .app_wdf_wren_o        (app_wdf_wren_o),
    .app_wdf_end_o         (app_wdf_end_o),
    .addr_load_o           (addr_load),
    .addr_step_o           (addr_step),
    .wr_pat_load_o         (wr_pat_load),
    .wr_pat_step_o         (wr_pat_step),
    .rd_pat_load_o         (rd_pat_load),
    .chk_clear_o           (chk_clear)
  );

  //******************************
  // Datapath
  //******************************
  ddr_addr_gen u_addr_gen (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n_i     (rst_n_i),
    .base_addr_i (base_addr_i),
    .load_i      (addr_load),
    .step_i      (addr_step),
    .addr_o      (app_addr_o)
  );

  // Write stream
  ddr_pattern_gen u_wr_pat (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n_i     (rst_n_i),
    .seed_i      (seed_i),
    .load_i      (wr_pat_load),
    .step_i      (wr_pat_step),
    .data_o      (app_wdf_data_o)
  );

  // Expected read stream, same seed
  ddr_pattern_gen u_rd_pat (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n_i     (rst_n_i),
    .seed_i      (seed_i),
    .load_i      (rd_pat_load),
    .step_i      (rd_pat_step),
    .data_o      (exp_data)
  );

  // Read addresses track from the test base
  ddr_read_checker u_checker (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .rst_n_i          (rst_n_i),
    .clear_i          (chk_clear),
    .rd_valid_i       (app_rd_data_valid_i),
    .rd_data_i        (app_rd_data_i),
    .expected_i       (exp_data),
    .addr_i           (base_addr_i),
    .pat_step_o       (rd_pat_step),
    .compare_error_o  (compare_error_o),
    .error_count_o    (error_count_o),
    .first_err_addr_o (first_err_addr_o)
  );

endmodule

//--- ddr_read_checker.sv
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module ddr_read_checker (
  input  logic                   c0_ddr4_clk,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  logic                   rd_valid_i,
  input  ddr_app_pkg::app_data_t rd_data_i,
  input  ddr_app_pkg::app_data_t expected_i,
  input  ddr_app_pkg::app_addr_t addr_i,
  output logic                   pat_step_o,
  output logic                   compare_error_o,
  output ddr_test_pkg::err_cnt_t error_count_o,
  output ddr_app_pkg::app_addr_t first_err_addr_o
);

  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  app_addr_t rd_addr_q;
  logic      mismatch;

  assign mismatch   = rd_valid_i && (rd_data_i != expected_i);
  // Expected word advances with every returned word
  assign pat_step_o = rd_valid_i;

  //******************************
  // Sticky flag and error count
  //******************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      compare_error_o <= 1'b0;
      error_count_o   <= '0;
    end else if (clear_i) begin
      compare_error_o <= 1'b0;
      error_count_o   <= '0;
    end else if (mismatch) begin
      compare_error_o <= 1'b1;
      if (error_count_o != '1) begin
        error_count_o <= error_count_o + err_cnt_t'(1);
      end
    end
  end

  // Address of the word being returned, first mismatch latched once
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      rd_addr_q        <= '0;
      first_err_addr_o <= '0;
    end else if (clear_i) begin
      rd_addr_q        <= addr_i;
      first_err_addr_o <= '0;
    end else if (rd_valid_i) begin
      rd_addr_q <= rd_addr_q + app_addr_t'(`APP_ADDR_STEP);
      if (mismatch && !compare_error_o) begin
        first_err_addr_o <= rd_addr_q;
      end
    end
  end

  // Memory must be quiet while a new test clears the results
  a_no_data_on_clear: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    clear_i |-> !rd_valid_i);

endmodule

//--- ddr_pattern_gen.sv
`timescale 1ns/1ps

module ddr_pattern_gen (
  input  logic                   c0_ddr4_clk,
  input  logic                   rst_n_i,
  input  logic [31:0]            seed_i,
  input  logic                   load_i,
  input  logic                   step_i,
  output ddr_app_pkg::app_data_t data_o
);

  // Galois feedback for taps 32, 22, 2, 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic [31:0] lfsr_q;
  logic [31:0] lfsr_next;
  logic [31:0] seed_nz;

  // All-zero state would lock the LFSR
  assign seed_nz   = (seed_i == 32'd0) ? 32'd1 : seed_i;
  assign lfsr_next = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'd0);

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      lfsr_q <= 32'd1;
    end else if (load_i) begin
      lfsr_q <= seed_nz;
    end else if (step_i) begin
      lfsr_q <= lfsr_next;
    end
  end

  // Upper half is the state, lower half its inverse
  assign data_o = {lfsr_q, ~lfsr_q};

endmodule

//--- ddr_addr_gen.sv
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module ddr_addr_gen (
  input  logic                   c0_ddr4_clk,
  input  logic                   rst_n_i,
  input  ddr_app_pkg::app_addr_t base_addr_i,
  input  logic                   load_i,
  input  logic                   step_i,
  output ddr_app_pkg::app_addr_t addr_o
);

  import ddr_app_pkg::*;

  // Kept at address width so the sum wraps
  localparam app_addr_t ADDR_STEP = app_addr_t'(`APP_ADDR_STEP);

  // Load wins over step
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      addr_o <= '0;
    end else if (load_i) begin
      addr_o <= base_addr_i;
    end else if (step_i) begin
      addr_o <= addr_o + ADDR_STEP;
    end
  end

endmodule

//--- ddr_test_ctrl.sv
`timescale 1ns/1ps

module ddr_test_ctrl (
  input  logic                    c0_ddr4_clk,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  output logic                    ack_o,
  input  ddr_test_pkg::test_op_e  opcode_i,
  input  ddr_test_pkg::word_cnt_t word_count_i,
  input  logic                    init_calib_complete_i,
  input  logic                    app_rdy_i,
  input  logic                    app_wdf_rdy_i,
  input  logic                    app_rd_data_valid_i,
  output logic                    app_en_o,
  output ddr_app_pkg::app_cmd_e   app_cmd_o,
  output logic                    app_wdf_wren_o,
  output logic                    app_wdf_end_o,
  output logic                    addr_load_o,
  output logic                    addr_step_o,
  output logic                    wr_pat_load_o,
  output logic                    wr_pat_step_o,
  output logic                    rd_pat_load_o,
  output logic                    chk_clear_o
);

  import ddr_test_pkg::*;
  import ddr_app_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  ctrl_state_e first_phase;
  word_cnt_t   cmd_cnt_q;
  word_cnt_t   rd_outst_q;
  logic        launch;
  logic        wr_go;
  logic        rd_go;
  logic        last_cmd;

  // Command and write data move together, reads only need app_rdy
  assign wr_go       = (state_q == WRITE) && app_rdy_i && app_wdf_rdy_i;
  assign rd_go       = (state_q == READ) && app_rdy_i;
  assign last_cmd    = (cmd_cnt_q == word_count_i - word_cnt_t'(1));
  assign first_phase = (opcode_i == OP_READ_CHECK) ? READ : WRITE;
  assign launch      = init_calib_complete_i &&
                       (((state_q == IDLE) && req_i && (word_count_i != '0)) ||
                        (state_q == WAIT_CALIB));

  //******************************
  // Phase sequencing
  //******************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i && (word_count_i == '0)) begin
          state_d = DONE;
        end else if (launch) begin
          state_d = first_phase;
        end else if (req_i) begin
          state_d = WAIT_CALIB;
        end
      end
      WAIT_CALIB: begin
        if (launch) begin
          state_d = first_phase;
        end
      end
      WRITE: begin
        if (wr_go && last_cmd) begin
          state_d = (opcode_i == OP_WRITE_READ) ? READ : DONE;
        end
      end
      READ: begin
        if (rd_go && last_cmd) begin
          state_d = DRAIN;
        end
      end
      // Hold until the last read word has come back
      DRAIN: begin
        if (rd_outst_q == '0) begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      cmd_cnt_q  <= '0;
      rd_outst_q <= '0;
    end else begin
      state_q <= state_d;
      if (launch || (wr_go && last_cmd)) begin
        cmd_cnt_q <= '0;
      end else if (wr_go || rd_go) begin
        cmd_cnt_q <= cmd_cnt_q + word_cnt_t'(1);
      end
      // Reads in flight, no cap
      if (rd_go && !app_rd_data_valid_i) begin
        rd_outst_q <= rd_outst_q + word_cnt_t'(1);
      end else if (!rd_go && app_rd_data_valid_i) begin
        rd_outst_q <= rd_outst_q - word_cnt_t'(1);
      end
    end
  end

  //******************************
  // Outputs
  //******************************
  assign app_en_o       = (state_q == WRITE) || (state_q == READ);
  assign app_wdf_wren_o = (state_q == WRITE);
  assign app_wdf_end_o  = app_wdf_wren_o;
  assign app_cmd_o      = (state_q == READ) ? CMD_READ : CMD_WRITE;
  assign ack_o          = (state_q == DONE);

  // Address restarts at base for the read pass of a write-read test
  assign addr_load_o    = launch || (wr_go && last_cmd);
  assign addr_step_o    = wr_go || rd_go;
  assign wr_pat_load_o  = launch;
  assign wr_pat_step_o  = wr_go;
  assign rd_pat_load_o  = launch;
  assign chk_clear_o    = (state_q == IDLE) && req_i;

  a_ack_needs_req: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    $rose(ack_o) |-> req_i);

  a_cmd_held: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    app_en_o && !app_rdy_i |=> app_en_o && $stable(app_cmd_o));

endmodule

//--- ddr_test_pkg.sv
`include "ddr_test_defines.svh"

package ddr_test_pkg;

  // Host opcodes
  typedef enum logic [1:0] {
    OP_WRITE      = 2'd0,
    OP_READ_CHECK = 2'd1,
    OP_WRITE_READ = 2'd2
  } test_op_e;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_CALIB,
    WRITE,
    READ,
    DRAIN,
    DONE
  } ctrl_state_e;

  // Words per test, also used for in-flight reads
  typedef logic [15:0] word_cnt_t;

  typedef logic [`ERR_CNT_WIDTH-1:0] err_cnt_t;

endpackage

//--- ddr_app_pkg.sv
`include "ddr_test_defines.svh"

package ddr_app_pkg;

  // Native command encoding of the controller
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

  // Application address, wraps at the top of the space
  typedef logic [`APP_ADDR_WIDTH-1:0] app_addr_t;

  // One data word per command
  typedef logic [`APP_DATA_WIDTH-1:0] app_data_t;

endpackage

//--- ddr_test_defines.svh
`ifndef DDR_TEST_DEFINES_SVH
`define DDR_TEST_DEFINES_SVH

// Native application interface widths of the memory controller
`define APP_DATA_WIDTH 64
`define APP_ADDR_WIDTH 28

// Address advance per data word
`define APP_ADDR_STEP 8

// Mismatch counter, saturates at all ones
`define ERR_CNT_WIDTH 16

`endif
